/* coef_arbiter.sv */
`timescale 1ns/100ps

module coef_arbiter (
  input  logic        clk,
  input  logic        rst_n,
  coef_bus_if.arbiter load_bus,
  coef_bus_if.arbiter fetch_bus
);

  lrelu_pkg::coef_t mem [coef_pkg::coef_depth];   // upper 7 entries unused

  logic [1:0] req_v;    // bit 0 load, bit 1 fetch
  logic [1:0] ack_q;
  logic [1:0] gnt_q;    // one-hot owner of the memory
  logic [1:0] access;   // granted and not yet acknowledged

  logic                 acc_we;
  coef_pkg::coef_addr_t acc_addr;
  lrelu_pkg::coef_t     acc_wdata;
  lrelu_pkg::coef_t     rdata_q;

  assign req_v  = {fetch_bus.req, load_bus.req};
  assign access = gnt_q & req_v & ~ack_q;

  // fields of the bus holding the grant
  always_comb begin
    if (gnt_q[1]) begin
      acc_we    = fetch_bus.we;
      acc_addr  = fetch_bus.addr;
      acc_wdata = fetch_bus.wdata;
    end else begin
      acc_we    = load_bus.we;
      acc_addr  = load_bus.addr;
      acc_wdata = load_bus.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gnt_q <= '0;
      ack_q <= '0;
    end else begin
      if (gnt_q == 2'b00) begin
        if (req_v[0])
          gnt_q <= 2'b01;          // load wins
        else if (req_v[1])
          gnt_q <= 2'b10;
      end
      for (int i = 0; i < 2; i++) begin
        if (access[i]) begin
          ack_q[i] <= 1'b1;        // access happens this edge
        end else if (ack_q[i] && !req_v[i]) begin
          ack_q[i] <= 1'b0;        // req gone, release the memory
          gnt_q[i] <= 1'b0;
        end
      end
    end
  end

  // one access per grant
  always_ff @(posedge clk) begin
    if (|access) begin
      if (acc_we)
        mem[acc_addr] <= acc_wdata;
      rdata_q <= mem[acc_addr];
    end
  end

  // rdata_q holds while ack is up, nothing else touches it then
  assign load_bus.rdata  = rdata_q;
  assign fetch_bus.rdata = rdata_q;
  assign load_bus.ack    = ack_q[0];
  assign fetch_bus.ack   = ack_q[1];

endmodule

/* coef_bus_if.sv */
`timescale 1ns/100ps

interface coef_bus_if;

  logic                 req;
  logic                 ack;
  logic                 we;      // 1 write, 0 read
  coef_pkg::coef_addr_t addr;
  lrelu_pkg::coef_t     wdata;
  lrelu_pkg::coef_t     rdata;   // valid while ack is high

  // four-phase, requester holds its fields until ack
  modport requester (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

/* coef_fetch.sv */
`timescale 1ns/100ps

module coef_fetch (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load_busy,
  input  logic             load_done,
  coef_bus_if.requester    bus,
  output lrelu_pkg::coef_t coef_a [lrelu_pkg::n_channels],
  output lrelu_pkg::coef_t coef_b [lrelu_pkg::n_channels],
  output lrelu_pkg::coef_t coef_d,
  output logic             coef_valid
);

  coef_pkg::fetch_state_t state;
  coef_pkg::coef_addr_t   rd_cnt;   // address being read
  lrelu_pkg::chan_t       a_idx;
  lrelu_pkg::chan_t       b_idx;
  logic                   last_word;

  assign a_idx     = lrelu_pkg::chan_t'(rd_cnt - coef_pkg::addr_a_base);
  assign b_idx     = lrelu_pkg::chan_t'(rd_cnt - coef_pkg::addr_b_base);
  assign last_word = (rd_cnt == coef_pkg::coef_addr_t'(coef_pkg::n_coef_words - 1));

  assign bus.we    = 1'b0;   // read only
  assign bus.wdata = '0;
  assign bus.addr  = rd_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= coef_pkg::fe_wait_load;
      rd_cnt     <= '0;
      bus.req    <= 1'b0;
      coef_valid <= 1'b0;
      coef_a     <= '{default: '0};
      coef_b     <= '{default: '0};
      coef_d     <= '0;
    end else begin
      case (state)
        coef_pkg::fe_wait_load: begin
          if (load_done) begin
            rd_cnt  <= '0;
            bus.req <= 1'b1;
            state   <= coef_pkg::fe_request;
          end
        end

        coef_pkg::fe_request: begin
          if (bus.ack) begin
            if (rd_cnt == coef_pkg::addr_d)
              coef_d <= bus.rdata;
            else if (rd_cnt < coef_pkg::addr_b_base)
              coef_a[a_idx] <= bus.rdata;
            else
              coef_b[b_idx] <= bus.rdata;
            bus.req <= 1'b0;
            state   <= coef_pkg::fe_drop;
          end
        end

        coef_pkg::fe_drop: begin
          if (!bus.ack) begin
            if (load_busy) begin
              state <= coef_pkg::fe_wait_load;   // a newer load overtook this fetch
            end else if (last_word) begin
              state <= coef_pkg::fe_done;
            end else begin
              rd_cnt  <= rd_cnt + 1'b1;
              bus.req <= 1'b1;
              state   <= coef_pkg::fe_request;
            end
          end
        end

        coef_pkg::fe_done: begin
          coef_valid <= 1'b1;
          state      <= coef_pkg::fe_wait_load;
        end

        default: state <= coef_pkg::fe_wait_load;
      endcase

      if (load_busy)
        coef_valid <= 1'b0;   // stream held off for the whole load
    end
  end

endmodule

/* coef_loader.sv */
`timescale 1ns/100ps

module coef_loader (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cfg_req,
  input  lrelu_pkg::coef_t cfg_data,
  output logic             cfg_ack,
  output logic             load_busy,
  output logic             load_done,
  coef_bus_if.requester    bus
);

  coef_pkg::loader_state_t state;
  coef_pkg::coef_addr_t    word_cnt;   // position in the load
  logic                    last_word;

  assign last_word = (word_cnt == coef_pkg::coef_addr_t'(coef_pkg::n_coef_words - 1));

  // words arrive in memory order, so the counter is the address
  assign bus.we    = 1'b1;
  assign bus.addr  = word_cnt;
  assign bus.wdata = cfg_data;   // host keeps it stable until cfg_ack

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= coef_pkg::ld_idle;
      word_cnt  <= '0;
      bus.req   <= 1'b0;
      cfg_ack   <= 1'b0;
      load_busy <= 1'b0;
      load_done <= 1'b0;
    end else begin
      load_done <= 1'b0;   // single cycle pulse
      case (state)
        coef_pkg::ld_idle: begin
          if (cfg_req) begin
            bus.req   <= 1'b1;
            load_busy <= 1'b1;   // stays up until the ninth word lands
            state     <= coef_pkg::ld_write;
          end
        end

        coef_pkg::ld_write: begin
          if (bus.ack) begin
            bus.req <= 1'b0;
            cfg_ack <= 1'b1;     // word is in memory
            if (last_word) begin
              word_cnt  <= '0;   // next load starts at D
              load_busy <= 1'b0;
              load_done <= 1'b1;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
            state <= coef_pkg::ld_ack;
          end
        end

        coef_pkg::ld_ack: begin
          if (!cfg_req) begin
            cfg_ack <= 1'b0;
            state   <= coef_pkg::ld_release;
          end
        end

        coef_pkg::ld_release: begin
          // no new bus req until the arbiter has dropped ack
          if (!bus.ack)
            state <= coef_pkg::ld_idle;
        end

        default: state <= coef_pkg::ld_idle;
      endcase
    end
  end

endmodule

/* coef_pkg.sv */
package coef_pkg;

  localparam int coef_depth  = 16;
  localparam int coef_addr_w = $clog2(coef_depth);

  // memory layout matches the arrival order on the config port
  localparam int addr_d       = 0;    // shared D
  localparam int addr_a_base  = 1;    // A[ch] at 1+ch
  localparam int addr_b_base  = 5;    // B[ch] at 5+ch
  localparam int n_coef_words = 9;

  typedef logic [coef_addr_w-1:0] coef_addr_t;

  // one config handshake bridged into one bus write
  typedef enum logic [1:0] {
    ld_idle,
    ld_write,     // bus write pending
    ld_ack,       // cfg_ack high, waiting for cfg_req low
    ld_release    // waiting for bus ack low
  } loader_state_t;

  typedef enum logic [1:0] {
    fe_wait_load,
    fe_request,   // read pending
    fe_drop,      // req dropped, waiting for ack low
    fe_done
  } fetch_state_t;

endpackage

/* lrelu_engine.f */
lrelu_pkg.sv
coef_pkg.sv
coef_bus_if.sv
coef_arbiter.sv
coef_loader.sv
coef_fetch.sv
lrelu_pipe.sv
lrelu_engine.sv
lrelu_engine_properties.sv
tb_lrelu_engine.sv

/* lrelu_engine.sv */
`timescale 1ns/100ps

module lrelu_engine (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cfg_req,
  input  lrelu_pkg::coef_t   cfg_data,
  output logic               cfg_ack,
  input  logic               s_valid,
  input  lrelu_pkg::sample_t s_data,
  input  lrelu_pkg::chan_t   s_chan,
  input  logic               s_lrelu,
  output logic               s_ready,
  output logic               m_valid,
  output lrelu_pkg::result_t m_data
);

  coef_bus_if load_bus ();
  coef_bus_if fetch_bus ();

  logic             load_busy;
  logic             load_done;
  lrelu_pkg::coef_t coef_a [lrelu_pkg::n_channels];
  lrelu_pkg::coef_t coef_b [lrelu_pkg::n_channels];
  lrelu_pkg::coef_t coef_d;

  // shared coefficient memory, load has priority
  coef_arbiter arbiter_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_bus  (load_bus),
    .fetch_bus (fetch_bus)
  );

  coef_loader loader_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_req   (cfg_req),
    .cfg_data  (cfg_data),
    .cfg_ack   (cfg_ack),
    .load_busy (load_busy),
    .load_done (load_done),
    .bus       (load_bus)
  );

  // coef_valid doubles as the stream ready
  coef_fetch fetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_busy  (load_busy),
    .load_done  (load_done),
    .bus        (fetch_bus),
    .coef_a     (coef_a),
    .coef_b     (coef_b),
    .coef_d     (coef_d),
    .coef_valid (s_ready)
  );

  lrelu_pipe pipe_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_valid    (s_valid),
    .s_data     (s_data),
    .s_chan     (s_chan),
    .s_lrelu    (s_lrelu),
    .coef_a     (coef_a),
    .coef_b     (coef_b),
    .coef_d     (coef_d),
    .coef_valid (s_ready),
    .m_valid    (m_valid),
    .m_data     (m_data)
  );

endmodule

/* lrelu_engine_properties.sv */
`timescale 1ns/100ps

module lrelu_engine_properties (
  input logic clk,
  input logic rst_n,
  input logic cfg_req,
  input logic cfg_ack,
  input logic s_valid,
  input logic s_ready,
  input logic m_valid,
  input logic load_busy,
  input logic load_ack,
  input logic fetch_ack
);

  // host drops cfg_req before the loader may drop cfg_ack
  cfg_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_ack && cfg_req |=> cfg_ack)
    else $error("cfg_ack fell while cfg_req was still high");

  pipe_latency: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid == $past(s_valid && s_ready, 3))
    else $error("m_valid does not follow an accepted sample by 3 cycles");

  // s_ready drops one cycle after load_busy
  ready_in_load: assert property (@(posedge clk) disable iff (!rst_n)
    load_busy |=> !s_ready)
    else $error("s_ready high during a coefficient load");

  one_ack: assert property (@(posedge clk) disable iff (!rst_n)
    !(load_ack && fetch_ack))
    else $error("both coefficient bus acks high");

endmodule

bind lrelu_engine lrelu_engine_properties props_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .cfg_req   (cfg_req),
  .cfg_ack   (cfg_ack),
  .s_valid   (s_valid),
  .s_ready   (s_ready),
  .m_valid   (m_valid),
  .load_busy (load_busy),
  .load_ack  (load_bus.ack),
  .fetch_ack (fetch_bus.ack)
);

/* lrelu_pipe.sv */
`timescale 1ns/100ps

module lrelu_pipe (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               s_valid,
  input  lrelu_pkg::sample_t s_data,
  input  lrelu_pkg::chan_t   s_chan,
  input  logic               s_lrelu,
  input  lrelu_pkg::coef_t   coef_a [lrelu_pkg::n_channels],
  input  lrelu_pkg::coef_t   coef_b [lrelu_pkg::n_channels],
  input  lrelu_pkg::coef_t   coef_d,
  input  logic               coef_valid,
  output logic               m_valid,
  output lrelu_pkg::result_t m_data
);

  logic accept;

  // stage 1, scaled sample
  logic             s1_valid;
  logic             s1_lrelu;
  lrelu_pkg::chan_t s1_chan;
  lrelu_pkg::acc_t  s1_acc;

  // stage 2, biased and activated
  logic             s2_valid;
  lrelu_pkg::acc_t  s2_acc;

  lrelu_pkg::acc_t    bias_sum;
  lrelu_pkg::acc_t    act;
  lrelu_pkg::acc_t    d_sum;
  lrelu_pkg::result_t sat;

  assign accept = s_valid && coef_valid;   // samples outside s_ready are dropped

  // B and the leaky slope
  always_comb begin
    bias_sum = s1_acc + lrelu_pkg::acc_t'(coef_b[s1_chan]);
    if (s1_lrelu && bias_sum < 0)
      act = (bias_sum * lrelu_pkg::acc_t'(lrelu_pkg::lrelu_alpha))
            >>> lrelu_pkg::alpha_frac_bits;
    else
      act = bias_sum;
  end

  // add D and clamp to 8 bits
  always_comb begin
    d_sum = s2_acc + lrelu_pkg::acc_t'(coef_d);
    if (d_sum > lrelu_pkg::result_max)
      sat = lrelu_pkg::result_t'(lrelu_pkg::result_max);
    else if (d_sum < lrelu_pkg::result_min)
      sat = lrelu_pkg::result_t'(lrelu_pkg::result_min);
    else
      sat = lrelu_pkg::result_t'(d_sum);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      m_valid  <= 1'b0;
    end else begin
      s1_valid <= accept;
      s2_valid <= s1_valid;
      m_valid  <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_acc <= (lrelu_pkg::acc_t'(s_data) * lrelu_pkg::acc_t'(coef_a[s_chan]))
              >>> lrelu_pkg::frac_bits;   // back to integer scale
    s1_chan  <= s_chan;
    s1_lrelu <= s_lrelu;
    s2_acc   <= act;
    m_data   <= sat;
  end

endmodule

/* lrelu_pkg.sv */
package lrelu_pkg;

  // widths on the sample path
  localparam int sample_w = 16;
  localparam int result_w = 8;
  localparam int coef_w   = 16;       // Q8.8
  localparam int acc_w    = 32;       // holds x*A and the alpha product

  localparam int n_channels = 4;
  localparam int chan_w     = $clog2(n_channels);

  localparam int frac_bits = 8;       // fraction bits of A

  // leaky slope in Q0.8
  localparam int lrelu_alpha     = 26;    // 26/256, about 0.1
  localparam int alpha_frac_bits = 8;

  // output clamp
  localparam int result_max = (1 << (result_w - 1)) - 1;
  localparam int result_min = -(1 << (result_w - 1));

  typedef logic signed [sample_w-1:0] sample_t;
  typedef logic signed [result_w-1:0] result_t;
  typedef logic signed [coef_w-1:0]   coef_t;
  typedef logic signed [acc_w-1:0]    acc_t;
  typedef logic [chan_w-1:0]          chan_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f lrelu_engine.f --top-module tb_lrelu_engine

out=$(./obj_dir/Vtb_lrelu_engine 2>&1 || true)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
  exit 0
else
  exit 1
fi

/* tb_lrelu_engine.sv */
`timescale 1ns/100ps

module tb_lrelu_engine;

  localparam int max_cycles = 4000;   // all tests take about 1500

  logic               clk;
  logic               rst_n;
  logic               cfg_req;
  lrelu_pkg::coef_t   cfg_data;
  logic               cfg_ack;
  logic               s_valid;
  lrelu_pkg::sample_t s_data;
  lrelu_pkg::chan_t   s_chan;
  logic               s_lrelu;
  logic               s_ready;
  logic               m_valid;
  lrelu_pkg::result_t m_data;

  int    seed   = 1180;
  int    cycle  = 0;
  int    errors = 0;
  int    n_pass = 0;
  int    n_fail = 0;
  int    n_hi   = 0;   // outputs at +127
  int    n_lo   = 0;   // outputs at -128
  string cur_test;
  int    exp_q [$];
  int    t_q [$];     // accept cycle of each expected result

  lrelu_pkg::coef_t words [coef_pkg::n_coef_words];   // last set sent to the DUT
  lrelu_pkg::coef_t cur_c [coef_pkg::n_coef_words];   // set the pipe works with

  lrelu_engine dut_i (.*);

  always #20 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    wait (cycle >= max_cycles);
    $display("timeout, run stopped after %0d cycles", max_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // x*A>>8 + B, leaky slope of 26/256 on negatives, + D, clamp
  function automatic int expected_result(input int x, input int a, input int b, input int d,
                                         input bit lr);
    int acc;
    acc = ((x * a) >>> 8) + b;
    if (lr && acc < 0)
      acc = (acc * 26) >>> 8;
    acc = acc + d;
    if (acc > 127)
      acc = 127;
    else if (acc < -128)
      acc = -128;
    return acc;
  endfunction

  task automatic compare_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    int exp_v;
    int t0;
    if (rst_n) begin
      if (!s_ready)
        cur_c = words;   // working registers follow the load
      if (m_valid) begin
        if (exp_q.size() == 0) begin
          $display("%s: output appeared with no sample in flight", cur_test);
          errors++;
        end else begin
          exp_v = exp_q.pop_front();
          t0    = t_q.pop_front();
          compare_value(cur_test, exp_v, m_data);
          compare_value({cur_test, " latency"}, 3, cycle - t0);
        end
        if (m_data == 127)
          n_hi++;
        if (m_data == -128)
          n_lo++;
      end
      if (s_valid && s_ready) begin
        exp_q.push_back(expected_result(s_data, cur_c[coef_pkg::addr_a_base + s_chan],
                                        cur_c[coef_pkg::addr_b_base + s_chan],
                                        cur_c[coef_pkg::addr_d], s_lrelu));
        t_q.push_back(cycle);
      end
    end
  end

  task automatic random_words(input int a_range, input int b_range, input int d_range);
    words[coef_pkg::addr_d] = lrelu_pkg::coef_t'($random(seed) % d_range);
    for (int ch = 0; ch < lrelu_pkg::n_channels; ch++) begin
      words[coef_pkg::addr_a_base + ch] = lrelu_pkg::coef_t'($random(seed) % a_range);
      words[coef_pkg::addr_b_base + ch] = lrelu_pkg::coef_t'($random(seed) % b_range);
    end
  endtask

  // four-phase handshake per word, D then A0..A3 then B0..B3
  task automatic load_coefs();
    for (int i = 0; i < coef_pkg::n_coef_words; i++) begin
      @(posedge clk);
      cfg_req  <= 1'b1;
      cfg_data <= words[i];
      do @(posedge clk); while (!cfg_ack);
      if (i == 0)
        compare_value({cur_test, " s_ready in load"}, 0, s_ready);
      cfg_req <= 1'b0;
      do @(posedge clk); while (cfg_ack);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!s_ready && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (!s_ready) begin
      $display("%s: s_ready did not rise after the load", cur_test);
      errors++;
    end
  endtask

  // lrelu_mode 0 clear, 1 set, 2 random; x_range 0 means full width
  task automatic stream_samples(input int n, input int lrelu_mode, input int x_range,
                                input bit dense);
    int sent;
    int r;
    sent = 0;
    while (sent < n) begin
      @(posedge clk);
      r = $random(seed);
      if (s_ready && (dense || r[1:0] != 2'b00)) begin
        s_valid <= 1'b1;
        s_data  <= (x_range == 0) ? lrelu_pkg::sample_t'($random(seed))
                                  : lrelu_pkg::sample_t'($random(seed) % x_range);
        s_chan  <= lrelu_pkg::chan_t'($random(seed));
        s_lrelu <= (lrelu_mode == 2) ? r[4] : (lrelu_mode == 1);
        sent++;
      end else begin
        s_valid <= 1'b0;
      end
    end
    @(posedge clk);
    s_valid <= 1'b0;
  endtask

  task automatic drain();
    @(posedge clk);
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic end_test(input int err_before);
    drain();
    if (errors == err_before) begin
      $display("test %s: ok", cur_test);
      n_pass++;
    end else begin
      $display("test %s: %0d errors", cur_test, errors - err_before);
      n_fail++;
    end
  endtask

  initial begin
    int e0;
    clk      = 1'b0;
    rst_n    = 1'b0;
    cfg_req  = 1'b0;
    cfg_data = '0;
    s_valid  = 1'b0;
    s_data   = '0;
    s_chan   = '0;
    s_lrelu  = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    cur_test = "load";
    e0 = errors;
    random_words(512, 64, 32);   // A within +-2.0
    load_coefs();
    wait_ready();
    end_test(e0);

    cur_test = "linear";
    e0 = errors;
    stream_samples(200, 0, 200, 1'b0);
    end_test(e0);

    cur_test = "leaky";
    e0 = errors;
    stream_samples(150, 1, 200, 1'b0);
    end_test(e0);

    cur_test = "saturate";
    e0 = errors;
    words = '{16'sh0000, 16'sh4000, -16'sh4000, 16'sh2000, -16'sh2000,
              16'sh0000, 16'sh0000, 16'sh0000, 16'sh0000};
    load_coefs();
    wait_ready();
    n_hi = 0;
    n_lo = 0;
    stream_samples(60, 0, 0, 1'b0);
    drain();
    if (n_hi == 0 || n_lo == 0) begin
      $display("%s: outputs never reached both clamp limits", cur_test);
      errors++;
    end
    end_test(e0);

    cur_test = "reload";
    e0 = errors;
    fork
      stream_samples(120, 2, 200, 1'b0);
      begin
        repeat (10) @(posedge clk);
        random_words(512, 64, 32);
        load_coefs();
      end
    join
    wait_ready();
    stream_samples(40, 2, 200, 1'b0);   // must see the new set
    end_test(e0);

    cur_test = "back_to_back";
    e0 = errors;
    stream_samples(40, 2, 200, 1'b1);
    end_test(e0);

    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
